/* common/rvCorePkg.sv */
package rvCorePkg;

  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] word_t;

  // ====================
  // Major opcodes
  // ====================
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opSystem = 7'b1110011;

  // ====================
  // Control encodings
  // ====================
  typedef enum logic [1:0] {
    aluAdd   = 2'd0,
    aluSub   = 2'd1,
    aluPassB = 2'd2
  } aluOp_e;

  // Same order as the write-back key
  typedef enum logic [1:0] {
    wbMem     = 2'd0,
    wbAlu     = 2'd1,
    wbPcPlus4 = 2'd2
  } wbSel_e;

  typedef enum logic [2:0] {
    immI = 3'd0,
    immS = 3'd1,
    immU = 3'd2,
    immJ = 3'd3
  } immSel_e;

  // One bundle per instruction
  typedef struct packed {
    logic    regWrite;
    logic    memWrite;
    wbSel_e  wbSel;
    logic    aluASel;   // 1 selects pc
    logic    aluBSel;   // 1 selects imm
    aluOp_e  aluOp;
    immSel_e immSel;
    logic    jump;      // next pc from ALU result
    logic    halt;      // ebreak
  } ctrl_t;

endpackage

/* verilog/alu.sv */
`timescale 1ns/10ps

module alu (
  input  rvCorePkg::word_t  a,
  input  rvCorePkg::word_t  b,
  input  rvCorePkg::aluOp_e op,
  output rvCorePkg::word_t  result
);

  always_comb begin
    case (op)
      rvCorePkg::aluAdd: begin
        result = a + b;
      end
      rvCorePkg::aluSub: begin
        result = a - b;
      end
      // lui
      rvCorePkg::aluPassB: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* verilog/immGen.sv */
`timescale 1ns/10ps

module immGen (
  input  rvCorePkg::word_t   inst,
  input  rvCorePkg::immSel_e immSel,
  output rvCorePkg::word_t   imm
);

  always_comb begin
    case (immSel)
      rvCorePkg::immI: begin
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      rvCorePkg::immS: begin
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      rvCorePkg::immU: begin
        imm = {inst[31:12], 12'b0};
      end
      rvCorePkg::immJ: begin
        // Scrambled jal offset, always even
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

/* verilog/regFile.sv */
`timescale 1ns/10ps

module regFile #(
  parameter int unsigned regAddrW = 5
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                wEn,
  input  logic [regAddrW-1:0] wAddr,
  input  logic [regAddrW-1:0] rAddr1,
  input  logic [regAddrW-1:0] rAddr2,
  input  rvCorePkg::word_t    wData,
  output rvCorePkg::word_t    rData1,
  output rvCorePkg::word_t    rData2
);

  localparam int unsigned nRegs = 2 ** regAddrW;

  rvCorePkg::word_t regs [nRegs];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < nRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wEn && wAddr != '0) begin
      regs[wAddr] <= wData;
    end
  end

  // x0 reads as zero
  assign rData1 = (rAddr1 == '0) ? '0 : regs[rAddr1];
  assign rData2 = (rAddr2 == '0) ? '0 : regs[rAddr2];

endmodule

/* verilog/rvDecoder.sv */
`timescale 1ns/10ps

module rvDecoder (
  input  rvCorePkg::word_t inst,
  input  logic             fetchValid,
  output rvCorePkg::ctrl_t ctrl
);

  rvCorePkg::ctrl_t dec;
  logic [2:0]       funct3;
  logic             funct7b5;

  assign funct3   = inst[14:12];
  assign funct7b5 = inst[30];

  // ====================
  // Opcode decode
  // ====================
  always_comb begin
    dec = '0;
    case (inst[6:0])
      rvCorePkg::opLui: begin
        dec.regWrite = 1'b1;
        dec.wbSel    = rvCorePkg::wbAlu;
        dec.aluBSel  = 1'b1;
        dec.aluOp    = rvCorePkg::aluPassB;
        dec.immSel   = rvCorePkg::immU;
      end
      rvCorePkg::opAuipc: begin
        dec.regWrite = 1'b1;
        dec.wbSel    = rvCorePkg::wbAlu;
        dec.aluASel  = 1'b1;
        dec.aluBSel  = 1'b1;
        dec.immSel   = rvCorePkg::immU;
      end
      rvCorePkg::opJal: begin
        dec.regWrite = 1'b1;
        dec.wbSel    = rvCorePkg::wbPcPlus4;
        dec.aluASel  = 1'b1;
        dec.aluBSel  = 1'b1;
        dec.immSel   = rvCorePkg::immJ;
        dec.jump     = 1'b1;
      end
      rvCorePkg::opJalr: begin
        if (funct3 == 3'b000) begin
          dec.regWrite = 1'b1;
          dec.wbSel    = rvCorePkg::wbPcPlus4;
          dec.aluBSel  = 1'b1;
          dec.immSel   = rvCorePkg::immI;
          dec.jump     = 1'b1;
        end
      end
      rvCorePkg::opOpImm: begin
        // addi only
        if (funct3 == 3'b000) begin
          dec.regWrite = 1'b1;
          dec.wbSel    = rvCorePkg::wbAlu;
          dec.aluBSel  = 1'b1;
          dec.immSel   = rvCorePkg::immI;
        end
      end
      rvCorePkg::opOp: begin
        if (funct3 == 3'b000) begin
          dec.regWrite = 1'b1;
          dec.wbSel    = rvCorePkg::wbAlu;
          dec.aluOp    = funct7b5 ? rvCorePkg::aluSub : rvCorePkg::aluAdd;
        end
      end
      rvCorePkg::opLoad: begin
        // lw only
        if (funct3 == 3'b010) begin
          dec.regWrite = 1'b1;
          dec.wbSel    = rvCorePkg::wbMem;
          dec.aluBSel  = 1'b1;
          dec.immSel   = rvCorePkg::immI;
        end
      end
      rvCorePkg::opStore: begin
        if (funct3 == 3'b010) begin
          dec.memWrite = 1'b1;
          dec.aluBSel  = 1'b1;
          dec.immSel   = rvCorePkg::immS;
        end
      end
      rvCorePkg::opSystem: begin
        // ebreak, not ecall
        if (funct3 == 3'b000 && inst[31:20] == 12'd1) begin
          dec.halt = 1'b1;
        end
      end
      default: dec = '0;
    endcase
  end

  // Side effects only on a valid fetch
  always_comb begin
    ctrl = dec;
    if (!fetchValid) begin
      ctrl.regWrite = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.jump     = 1'b0;
      ctrl.halt     = 1'b0;
    end
  end

endmodule

/* verilog/pcUnit.sv */
`timescale 1ns/10ps

module pcUnit #(
  parameter rvCorePkg::word_t resetVector = 32'h8000_0000
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             jump,
  input  logic             halt,
  input  rvCorePkg::word_t target,
  output rvCorePkg::word_t pc,
  output rvCorePkg::word_t pcPlus4,
  output logic             fetchValid,
  output logic             halted
);

  rvCorePkg::word_t nextPc;
  logic             started;

  assign pcPlus4    = pc + 32'd4;
  // jalr target needs bit 0 cleared
  assign nextPc     = jump ? {target[31:1], 1'b0} : pcPlus4;
  assign fetchValid = started && !halted;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc      <= resetVector;
      started <= 1'b0;
      halted  <= 1'b0;
    end else begin
      // One settling cycle after reset
      started <= 1'b1;
      if (halt) begin
        halted <= 1'b1;
      end else if (fetchValid) begin
        pc <= nextPc;
      end
    end
  end

endmodule

/* verilog/rvCoreTop.sv */
`timescale 1ns/10ps

module rvCoreTop #(
  parameter rvCorePkg::word_t resetVector = 32'h8000_0000,
  parameter int unsigned      regAddrW    = 5
) (
  input  logic             clk,
  input  logic             arstN,
  input  rvCorePkg::word_t inst,
  input  rvCorePkg::word_t memRData,
  output rvCorePkg::word_t pc,
  output rvCorePkg::word_t memAddr,
  output rvCorePkg::word_t memWData,
  output logic             memWEn,
  output logic             halted
);

  rvCorePkg::ctrl_t   ctrl;
  rvCorePkg::word_t   pcPlus4;
  rvCorePkg::word_t   imm;
  rvCorePkg::word_t   rData1;
  rvCorePkg::word_t   rData2;
  rvCorePkg::word_t   aluA;
  rvCorePkg::word_t   aluB;
  rvCorePkg::word_t   aluResult;
  rvCorePkg::word_t   regWData;
  logic               fetchValid;
  logic [regAddrW-1:0] rs1;
  logic [regAddrW-1:0] rs2;
  logic [regAddrW-1:0] rd;

  // ====================
  // Fetch and decode
  // ====================
  pcUnit #(
    .resetVector(resetVector)
  ) i_pcUnit (
    .clk       (clk),
    .arstN     (arstN),
    .jump      (ctrl.jump),
    .halt      (ctrl.halt),
    .target    (aluResult),
    .pc        (pc),
    .pcPlus4   (pcPlus4),
    .fetchValid(fetchValid),
    .halted    (halted)
  );

  rvDecoder i_rvDecoder (
    .inst      (inst),
    .fetchValid(fetchValid),
    .ctrl      (ctrl)
  );

  immGen i_immGen (
    .inst  (inst),
    .immSel(ctrl.immSel),
    .imm   (imm)
  );

  assign rs1 = inst[15 +: regAddrW];
  assign rs2 = inst[20 +: regAddrW];
  assign rd  = inst[7 +: regAddrW];

  regFile #(
    .regAddrW(regAddrW)
  ) i_regFile (
    .clk   (clk),
    .arstN (arstN),
    .wEn   (ctrl.regWrite),
    .wAddr (rd),
    .rAddr1(rs1),
    .rAddr2(rs2),
    .wData (regWData),
    .rData1(rData1),
    .rData2(rData2)
  );

  // ====================
  // Execute and memory
  // ====================
  assign aluA = ctrl.aluASel ? pc : rData1;
  assign aluB = ctrl.aluBSel ? imm : rData2;

  alu i_alu (
    .a     (aluA),
    .b     (aluB),
    .op    (ctrl.aluOp),
    .result(aluResult)
  );

  assign memAddr  = aluResult;
  assign memWData = rData2;
  assign memWEn   = ctrl.memWrite;

  // Write-back select
  always_comb begin
    case (ctrl.wbSel)
      rvCorePkg::wbMem:     regWData = memRData;
      rvCorePkg::wbAlu:     regWData = aluResult;
      rvCorePkg::wbPcPlus4: regWData = pcPlus4;
      default:              regWData = '0;
    endcase
  end

endmodule

/* sim/rvCore_asserts.sv */
`timescale 1ns/10ps

module rvCoreAsserts (
  input logic             clk,
  input logic             arstN,
  input logic             memWEn,
  input logic             halted,
  input rvCorePkg::word_t pc
);

  int unsigned failCount = 0;

  // No stores in reset or after ebreak
  noStoreWhenIdle: assert property (@(posedge clk) (!arstN || halted) |-> !memWEn)
    else begin
      failCount++;
      $error("memWEn high during reset or halt");
    end

  pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
    else begin
      failCount++;
      $error("pc not word aligned: %h", pc);
    end

  pcHeldWhenHalted: assert property (
    @(posedge clk) disable iff (!arstN) halted |=> $stable(pc)
  ) else begin
    failCount++;
    $error("pc moved while halted");
  end

endmodule

bind rvCoreTop rvCoreAsserts i_asserts (
  .clk   (clk),
  .arstN (arstN),
  .memWEn(memWEn),
  .halted(halted),
  .pc    (pc)
);

/* sim/rvCoreTb.sv */
`timescale 1ns/10ps

module rvCoreTb;

  localparam rvCorePkg::word_t resetVec   = 32'h8000_0000;
  localparam rvCorePkg::word_t ebreakInst = 32'h0010_0073;
  localparam int unsigned      cycleLimit = 400;

  logic             clk;
  logic             arstN;
  rvCorePkg::word_t inst;
  rvCorePkg::word_t memRData;
  rvCorePkg::word_t pc;
  rvCorePkg::word_t memAddr;
  rvCorePkg::word_t memWData;
  logic             memWEn;
  logic             halted;

  rvCorePkg::word_t imem [bit [29:0]];
  rvCorePkg::word_t dmem [bit [29:0]];
  rvCorePkg::word_t storeAddr [$];
  rvCorePkg::word_t storeData [$];
  rvCorePkg::word_t expAddr [$];
  rvCorePkg::word_t expData [$];
  int unsigned      progLen = 0;
  int unsigned      memEpoch = 0;
  int unsigned      cycles = 0;
  integer           seed;

  rvCoreTop i_dut (
    .clk     (clk),
    .arstN   (arstN),
    .inst    (inst),
    .memRData(memRData),
    .pc      (pc),
    .memAddr (memAddr),
    .memWData(memWData),
    .memWEn  (memWEn),
    .halted  (halted)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("FAIL: see errors above");
      $fatal(1, "timeout: core did not halt");
    end
  end

  // ====================
  // Memory models
  // ====================
  function automatic rvCorePkg::word_t fetchWord(input rvCorePkg::word_t a);
    if ($isunknown(a) || !imem.exists(a[31:2])) begin
      return '0;
    end
    return imem[a[31:2]];
  endfunction

  // Unwritten data reads back an address-derived pattern
  function automatic rvCorePkg::word_t readWord(input rvCorePkg::word_t a);
    if ($isunknown(a)) begin
      return '0;
    end
    return dmem.exists(a[31:2]) ? dmem[a[31:2]] : (a ^ 32'h5a3c_96e1);
  endfunction

  always @(pc or memAddr or memEpoch) begin
    inst     = fetchWord(pc);
    memRData = readWord(memAddr);
  end

  always @(posedge clk) begin
    if (arstN && memWEn) begin
      storeAddr.push_back(memAddr);
      storeData.push_back(memWData);
      dmem[memAddr[31:2]] = memWData;
      memEpoch++;
    end
  end

  // ====================
  // Encoders and helpers
  // ====================
  function automatic rvCorePkg::word_t rType(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, rvCorePkg::opOp};
  endfunction

  function automatic rvCorePkg::word_t iType(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rvCorePkg::word_t sType(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvCorePkg::opStore};
  endfunction

  function automatic rvCorePkg::word_t uType(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rvCorePkg::word_t jType(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvCorePkg::opJal};
  endfunction

  task automatic checkEq(input string name, input rvCorePkg::word_t actual,
                         input rvCorePkg::word_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic newProgram();
    imem.delete();
    dmem.delete();
    storeAddr.delete();
    storeData.delete();
    expAddr.delete();
    expData.delete();
    progLen = 0;
    memEpoch++;
  endtask

  task automatic emit(input rvCorePkg::word_t w);
    imem[resetVec[31:2] + progLen] = w;
    progLen++;
    memEpoch++;
  endtask

  task automatic expectStore(input rvCorePkg::word_t a, input rvCorePkg::word_t d);
    expAddr.push_back(a);
    expData.push_back(d);
  endtask

  task automatic runToHalt();
    arstN = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    checkEq("pc", pc, resetVec);
    checkEq("memWEn", memWEn, 0);
    checkEq("halted", halted, 0);
    arstN = 1'b1;
    while (!halted) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic compareStores();
    checkEq("storeCount", storeAddr.size(), expAddr.size());
    foreach (expAddr[i]) begin
      checkEq($sformatf("storeAddr[%0d]", i), storeAddr[i], expAddr[i]);
      checkEq($sformatf("storeData[%0d]", i), storeData[i], expData[i]);
    end
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic testReset();
    newProgram();
    emit(sType(12'h040, 5'd0, 5'd0));
    emit(ebreakInst);
    expectStore(32'h40, 32'h0);
    runToHalt();
    compareStores();
  endtask

  task automatic testArith();
    rvCorePkg::word_t x1;
    rvCorePkg::word_t x2;
    newProgram();
    x1 = (32'h12345 << 12) + 32'h678;
    x2 = 32'd0 - 32'd5;
    emit(uType(20'h12345, 5'd1, rvCorePkg::opLui));
    emit(iType(12'h678, 5'd1, 3'b000, 5'd1, rvCorePkg::opOpImm));
    // addi x2, x0, -5
    emit(iType(12'hffb, 5'd0, 3'b000, 5'd2, rvCorePkg::opOpImm));
    emit(rType(7'h00, 5'd2, 5'd1, 5'd3));
    emit(rType(7'h20, 5'd2, 5'd1, 5'd4));
    emit(iType(12'h001, 5'd1, 3'b000, 5'd0, rvCorePkg::opOpImm));
    emit(rType(7'h00, 5'd1, 5'd0, 5'd5));
    emit(sType(12'h100, 5'd3, 5'd0));
    emit(sType(12'h104, 5'd4, 5'd0));
    emit(sType(12'h108, 5'd0, 5'd0));
    emit(sType(12'h10c, 5'd5, 5'd0));
    emit(ebreakInst);
    expectStore(32'h100, x1 + x2);
    expectStore(32'h104, x1 - x2);
    expectStore(32'h108, 32'h0);
    expectStore(32'h10c, x1);
    runToHalt();
    compareStores();
  endtask

  task automatic testJumps();
    newProgram();
    emit(jType(21'd12, 5'd1));
    // Markers that must be skipped
    emit(sType(12'h200, 5'd0, 5'd0));
    emit(sType(12'h204, 5'd0, 5'd0));
    emit(uType(20'h00001, 5'd2, rvCorePkg::opAuipc));
    emit(uType(20'h00000, 5'd3, rvCorePkg::opAuipc));
    // Odd target x3 + 13
    emit(iType(12'd13, 5'd3, 3'b000, 5'd4, rvCorePkg::opJalr));
    emit(sType(12'h208, 5'd0, 5'd0));
    emit(sType(12'h300, 5'd1, 5'd0));
    emit(sType(12'h304, 5'd2, 5'd0));
    emit(sType(12'h308, 5'd4, 5'd0));
    emit(ebreakInst);
    expectStore(32'h300, resetVec + 32'd4);
    expectStore(32'h304, resetVec + 32'd12 + (32'd1 << 12));
    expectStore(32'h308, resetVec + 32'd24);
    runToHalt();
    compareStores();
  endtask

  task automatic testLoadStore();
    rvCorePkg::word_t a;
    rvCorePkg::word_t b;
    newProgram();
    a = $random(seed);
    b = $random(seed);
    dmem[30'h400] = a;
    dmem[30'h401] = b;
    memEpoch++;
    emit(uType(20'h00001, 5'd1, rvCorePkg::opLui));
    emit(iType(12'h010, 5'd1, 3'b000, 5'd1, rvCorePkg::opOpImm));
    emit(iType(12'hff0, 5'd1, 3'b010, 5'd2, rvCorePkg::opLoad));
    emit(iType(12'hff4, 5'd1, 3'b010, 5'd3, rvCorePkg::opLoad));
    emit(rType(7'h00, 5'd3, 5'd2, 5'd4));
    // addi x5, x4, -100
    emit(iType(12'hf9c, 5'd4, 3'b000, 5'd5, rvCorePkg::opOpImm));
    emit(sType(12'hff8, 5'd4, 5'd1));
    emit(sType(12'hffc, 5'd5, 5'd1));
    emit(iType(12'hffc, 5'd1, 3'b010, 5'd6, rvCorePkg::opLoad));
    emit(sType(12'h020, 5'd6, 5'd1));
    emit(ebreakInst);
    expectStore(32'h1008, a + b);
    expectStore(32'h100c, a + b - 32'd100);
    expectStore(32'h1030, a + b - 32'd100);
    runToHalt();
    compareStores();
  endtask

  task automatic testHalt();
    newProgram();
    emit(iType(12'h05a, 5'd0, 3'b000, 5'd1, rvCorePkg::opOpImm));
    // custom-0 opcode with store-like fields
    emit({7'h00, 5'd1, 5'd0, 3'b010, 5'd0, 7'b0001011});
    emit(ebreakInst);
    emit(sType(12'h400, 5'd1, 5'd0));
    emit(sType(12'h404, 5'd1, 5'd0));
    runToHalt();
    checkEq("pc", pc, resetVec + 32'd8);
    repeat (10) begin
      @(posedge clk);
      #1;
    end
    checkEq("halted", halted, 1);
    checkEq("pc", pc, resetVec + 32'd8);
    compareStores();
  endtask

  initial begin
    seed     = 32'ha6229dae;
    arstN    = 1'b0;
    inst     = '0;
    memRData = '0;
    testReset();
    testArith();
    testJumps();
    testLoadStore();
    testHalt();
    if (i_dut.i_asserts.failCount == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "concurrent assertions failed during the run");
    end
  end

endmodule

/* rvCore.f */
common/rvCorePkg.sv
verilog/alu.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/rvDecoder.sv
verilog/pcUnit.sv
verilog/rvCoreTop.sv
sim/rvCore_asserts.sv
sim/rvCoreTb.sv

/* Bender.yml */
package:
  name: rvCore

sources:
  - common/rvCorePkg.sv
  - verilog/alu.sv
  - verilog/immGen.sv
  - verilog/regFile.sv
  - verilog/rvDecoder.sv
  - verilog/pcUnit.sv
  - verilog/rvCoreTop.sv
  - target: simulation
    files:
      - sim/rvCore_asserts.sv
      - sim/rvCoreTb.sv
